/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary -j 0 --top-module l2_cache_tb -f l2_cache.f -o l2_cache_sim
	./obj_dir/l2_cache_sim | tee /dev/stderr | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir

/* eviction_write_buffer.sv */
`include "l2_cache_settings.svh"

module eviction_write_buffer
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 buf_load,
    input  l2_cache_pkg::l2_tag  victim_tag,
    input  l2_cache_pkg::l2_word mem_address,
    input  l2_cache_pkg::l2_line victim_data,
    input  logic                 wb_done,
    output logic                 buf_empty,
    output logic                 wb_req,
    output l2_cache_pkg::l2_word wb_address,
    output l2_cache_pkg::l2_line wb_data
);

    logic full;

    // The controller only loads an empty buffer, so load and done never meet.
    always_ff @(posedge clk)
    begin
        if (reset)
            full <= 1'b0;
        else if (buf_load)
            full <= 1'b1;
        else if (wb_done)
            full <= 1'b0;
    end

    // The victim shares the set index of the current request.
    always_ff @(posedge clk)
    begin
        if (buf_load)
        begin
            wb_address <= {victim_tag,
                           mem_address[`L2_TAG_LO-1:`L2_IDX_LO],
                           {`L2_IDX_LO{1'b0}}};
            wb_data <= victim_data;
        end
    end

    // A held line asks for the bus until memory takes it.
    assign wb_req = full;
    assign buf_empty = ~full;

endmodule : eviction_write_buffer

/* l2_cache.f */
+incdir+.
l2_cache_pkg.sv
l2_cache_control.sv
l2_cache_datapath.sv
eviction_write_buffer.sv
pmem_arbiter.sv
l2_cache.sv
l2_cache_checker.sv
l2_cache_tb.sv

/* l2_cache.sv */
`include "l2_cache_settings.svh"

module l2_cache
(
    input  logic                 clk,
    input  logic                 reset,
    input  l2_cache_pkg::l2_word mem_address,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  l2_cache_pkg::l2_line mem_wdata,
    output l2_cache_pkg::l2_line mem_rdata,
    output logic                 mem_resp,
    output l2_cache_pkg::l2_word pmem_address,
    output logic                 pmem_read,
    output logic                 pmem_write,
    output l2_cache_pkg::l2_line pmem_wdata,
    input  l2_cache_pkg::l2_line pmem_rdata,
    input  logic                 pmem_resp
);

    logic                 hit;
    logic                 victim_dirty;
    l2_cache_pkg::l2_tag  victim_tag;
    l2_cache_pkg::l2_line victim_data;
    logic                 ld_line;
    logic                 ld_write;
    logic                 ld_lru;
    logic                 buf_load;
    logic                 buf_empty;
    logic                 fill_req;
    logic                 fill_done;
    l2_cache_pkg::l2_line fill_data;
    l2_cache_pkg::l2_word fill_address;
    logic                 wb_req;
    logic                 wb_done;
    l2_cache_pkg::l2_word wb_address;
    l2_cache_pkg::l2_line wb_data;

    assign fill_address = {mem_address[`L2_ADDR_W-1:`L2_IDX_LO], {`L2_IDX_LO{1'b0}}};

    l2_cache_control control_i
    (
        .clk(clk), .reset(reset), .mem_address(mem_address),
        .mem_read(mem_read), .mem_write(mem_write), .hit(hit),
        .victim_dirty(victim_dirty), .buf_empty(buf_empty), .fill_done(fill_done),
        .mem_resp(mem_resp), .ld_line(ld_line), .ld_write(ld_write),
        .ld_lru(ld_lru), .buf_load(buf_load), .fill_req(fill_req)
    );

    l2_cache_datapath datapath_i
    (
        .clk(clk), .reset(reset), .mem_address(mem_address),
        .mem_wdata(mem_wdata), .fill_data(fill_data), .ld_line(ld_line),
        .ld_write(ld_write), .ld_lru(ld_lru), .hit(hit), .hit_way(),
        .victim_way(), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .victim_data(victim_data), .mem_rdata(mem_rdata)
    );

    eviction_write_buffer buffer_i
    (
        .clk(clk), .reset(reset), .buf_load(buf_load), .victim_tag(victim_tag),
        .mem_address(mem_address), .victim_data(victim_data), .wb_done(wb_done),
        .buf_empty(buf_empty), .wb_req(wb_req), .wb_address(wb_address),
        .wb_data(wb_data)
    );

    pmem_arbiter arbiter_i
    (
        .clk(clk), .reset(reset), .wb_req(wb_req), .wb_address(wb_address),
        .wb_data(wb_data), .fill_req(fill_req), .fill_address(fill_address),
        .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp), .wb_done(wb_done),
        .fill_done(fill_done), .fill_data(fill_data), .pmem_address(pmem_address),
        .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_wdata(pmem_wdata)
    );

endmodule : l2_cache

/* l2_cache_checker.sv */
`include "l2_cache_settings.svh"

module l2_cache_checker
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 expect_hit,
    input  l2_cache_pkg::l2_word mem_address,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  l2_cache_pkg::l2_line mem_wdata,
    input  l2_cache_pkg::l2_line mem_rdata,
    input  logic                 mem_resp,
    input  l2_cache_pkg::l2_word pmem_address,
    input  logic                 pmem_read,
    input  logic                 pmem_write,
    input  l2_cache_pkg::l2_line pmem_wdata,
    input  logic                 pmem_resp,
    output int                   error_count
);

    localparam int LINES = 1 << (`L2_ADDR_W - `L2_IDX_LO);

    l2_cache_pkg::l2_line ref_mem [LINES];
    logic requested;
    logic mem_used;

    // Each word of a line mixes the line address with the word position.
    function automatic l2_cache_pkg::l2_line line_pattern(input int line_addr);
        l2_cache_pkg::l2_line line;
        for (int k = 0; k < `L2_LINE_W / 16; k++)
            line[k*16 +: 16] = 16'((line_addr << 5) | k) ^ 16'h3c5a;
        return line;
    endfunction

    initial
    begin
        for (int a = 0; a < LINES; a++)
            ref_mem[a] = line_pattern(a);
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            error_count = 0;
            requested = 1'b0;
            mem_used = 1'b0;
        end
        else
        begin
            if (!requested && (mem_resp || pmem_read || pmem_write))
            begin
                $display("DUT output went high at %0t before any request was made", $time);
                error_count++;
            end
            if (mem_read || mem_write)
                requested = 1'b1;

            if (mem_resp && mem_read &&
                mem_rdata !== ref_mem[mem_address[`L2_ADDR_W-1:`L2_IDX_LO]])
            begin
                $display("FAIL mem_rdata at address %h: got %h, expected %h", mem_address,
                         mem_rdata, ref_mem[mem_address[`L2_ADDR_W-1:`L2_IDX_LO]]);
                error_count++;
            end
            if (mem_resp && mem_write)
                ref_mem[mem_address[`L2_ADDR_W-1:`L2_IDX_LO]] = mem_wdata;

            // A hit is answered without any physical memory traffic.
            if (mem_resp && (mem_read || mem_write))
            begin
                if (expect_hit && mem_used)
                begin
                    $display("Request to %h should have hit but physical memory was used",
                             mem_address);
                    error_count++;
                end
                mem_used = 1'b0;
            end
            else if (pmem_read || pmem_write)
                mem_used = 1'b1;

            // A write-back must carry the newest data of its own line.
            if (pmem_resp && pmem_write &&
                pmem_wdata !== ref_mem[pmem_address[`L2_ADDR_W-1:`L2_IDX_LO]])
            begin
                $display("FAIL pmem_wdata at address %h: got %h, expected %h", pmem_address,
                         pmem_wdata, ref_mem[pmem_address[`L2_ADDR_W-1:`L2_IDX_LO]]);
                error_count++;
            end
        end
    end

endmodule : l2_cache_checker

/* l2_cache_control.sv */
`include "l2_cache_settings.svh"

module l2_cache_control
(
    input  logic                 clk,
    input  logic                 reset,
    input  l2_cache_pkg::l2_word mem_address,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic                 hit,
    input  logic                 victim_dirty,
    input  logic                 buf_empty,
    input  logic                 fill_done,
    output logic                 mem_resp,
    output logic                 ld_line,
    output logic                 ld_write,
    output logic                 ld_lru,
    output logic                 buf_load,
    output logic                 fill_req
);

    l2_cache_pkg::l2_ctrl_state state;
    l2_cache_pkg::l2_ctrl_state next_state;
    logic [`L2_ADDR_W-`L2_IDX_LO-1:0] req_line;
    logic request;
    logic same_line;

    assign request = mem_read | mem_write;

    // The line seen in idle must still be the one asked for when we answer.
    assign same_line = (mem_address[`L2_ADDR_W-1:`L2_IDX_LO] == req_line);

    always_comb
    begin
        mem_resp = 1'b0;
        ld_line = 1'b0;
        ld_write = 1'b0;
        ld_lru = 1'b0;
        buf_load = 1'b0;
        fill_req = 1'b0;

        case (state)
            l2_cache_pkg::hit_respond:
            begin
                if (request && hit && same_line)
                begin
                    mem_resp = 1'b1;
                    ld_lru = 1'b1;
                    ld_write = mem_write;
                end
            end
            l2_cache_pkg::victim_capture:
            begin
                buf_load = 1'b1;
            end
            l2_cache_pkg::line_fill:
            begin
                fill_req = 1'b1;
                ld_line = fill_done;
            end
            default: ;
        endcase
    end

    always_comb
    begin
        next_state = state;

        case (state)
            l2_cache_pkg::idle:
            begin
                if (request && hit)
                    next_state = l2_cache_pkg::hit_respond;
                else if (request && victim_dirty && buf_empty)
                    next_state = l2_cache_pkg::victim_capture;
                else if (request && victim_dirty)
                    next_state = l2_cache_pkg::wait_buffer;
                else if (request)
                    next_state = l2_cache_pkg::line_fill;
            end
            l2_cache_pkg::wait_buffer:
            begin
                if (buf_empty)
                    next_state = l2_cache_pkg::victim_capture;
            end
            l2_cache_pkg::victim_capture:
            begin
                next_state = l2_cache_pkg::line_fill;
            end
            l2_cache_pkg::line_fill:
            begin
                // The filled line makes the held request hit from idle.
                if (fill_done)
                    next_state = l2_cache_pkg::idle;
            end
            default:
            begin
                next_state = l2_cache_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= l2_cache_pkg::idle;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (state == l2_cache_pkg::idle)
            req_line <= mem_address[`L2_ADDR_W-1:`L2_IDX_LO];
    end

endmodule : l2_cache_control

/* l2_cache_datapath.sv */
`include "l2_cache_settings.svh"

module l2_cache_datapath
(
    input  logic                  clk,
    input  logic                  reset,
    input  l2_cache_pkg::l2_word  mem_address,
    input  l2_cache_pkg::l2_line  mem_wdata,
    input  l2_cache_pkg::l2_line  fill_data,
    input  logic                  ld_line,
    input  logic                  ld_write,
    input  logic                  ld_lru,
    output logic                  hit,
    output l2_cache_pkg::l2_way   hit_way,
    output l2_cache_pkg::l2_way   victim_way,
    output logic                  victim_dirty,
    output l2_cache_pkg::l2_tag   victim_tag,
    output l2_cache_pkg::l2_line  victim_data,
    output l2_cache_pkg::l2_line  mem_rdata
);

    l2_cache_pkg::l2_line data_array [`L2_SETS][`L2_WAYS];
    l2_cache_pkg::l2_tag  tag_array [`L2_SETS][`L2_WAYS];
    logic [`L2_WAYS-1:0]  valid_array [`L2_SETS];
    logic [`L2_WAYS-1:0]  dirty_array [`L2_SETS];
    logic [2:0]           lru_array [`L2_SETS];

    l2_cache_pkg::l2_index index;
    l2_cache_pkg::l2_tag   tag;
    l2_cache_pkg::l2_way   access_way;
    logic [`L2_WAYS-1:0]   way_match;
    logic [2:0]            lru_bits;
    logic [2:0]            lru_next;

    assign index = mem_address[`L2_TAG_LO-1:`L2_IDX_LO];
    assign tag = mem_address[`L2_ADDR_W-1:`L2_TAG_LO];
    assign lru_bits = lru_array[index];

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            way_match[w] = valid_array[index][w] && (tag_array[index][w] == tag);
            if (way_match[w])
                hit_way = l2_cache_pkg::l2_way'(w);
        end
    end

    assign hit = |way_match;

    // Bit 0 picks the pair, bit 1 the way in the low pair, bit 2 in the high pair.
    // An empty way is always taken before the tree is consulted.
    always_comb
    begin
        victim_way = {lru_bits[0], lru_bits[0] ? lru_bits[2] : lru_bits[1]};
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (!valid_array[index][w])
                victim_way = l2_cache_pkg::l2_way'(w);
        end
    end

    assign access_way = hit ? hit_way : victim_way;

    always_comb
    begin
        lru_next = lru_bits;
        lru_next[0] = ~access_way[1];
        if (access_way[1])
            lru_next[2] = ~access_way[0];
        else
            lru_next[1] = ~access_way[0];
    end

    assign victim_dirty = valid_array[index][victim_way] & dirty_array[index][victim_way];
    assign victim_tag = tag_array[index][victim_way];
    assign victim_data = data_array[index][victim_way];
    assign mem_rdata = data_array[index][hit_way];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s < `L2_SETS; s++)
            begin
                valid_array[s] <= '0;
                dirty_array[s] <= '0;
                lru_array[s] <= '0;
            end
        end
        else
        begin
            if (ld_line)
            begin
                valid_array[index][victim_way] <= 1'b1;
                dirty_array[index][victim_way] <= 1'b0;
            end
            if (ld_write)
                dirty_array[index][hit_way] <= 1'b1;
            if (ld_lru)
                lru_array[index] <= lru_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ld_line)
        begin
            data_array[index][victim_way] <= fill_data;
            tag_array[index][victim_way] <= tag;
        end
        if (ld_write)
            data_array[index][hit_way] <= mem_wdata;
    end

endmodule : l2_cache_datapath

/* l2_cache_pkg.sv */
`include "l2_cache_settings.svh"

package l2_cache_pkg;

    typedef logic [`L2_ADDR_W-1:0] l2_word;
    typedef logic [`L2_ADDR_W-`L2_TAG_LO-1:0] l2_tag;
    typedef logic [`L2_TAG_LO-`L2_IDX_LO-1:0] l2_index;
    typedef logic [$clog2(`L2_WAYS)-1:0] l2_way;
    typedef logic [`L2_LINE_W-1:0] l2_line;

    typedef enum logic [2:0] {
        idle,
        hit_respond,
        victim_capture,
        wait_buffer,
        line_fill
    } l2_ctrl_state;

    typedef enum logic [1:0] {
        owner_none,
        owner_buffer,
        owner_fill
    } l2_bus_owner;

endpackage : l2_cache_pkg

/* l2_cache_settings.svh */
`ifndef L2_CACHE_SETTINGS_SVH
`define L2_CACHE_SETTINGS_SVH

// Processor word addresses are 16 bits wide.
`define L2_ADDR_W 16

// A line is 32 bytes, moved as one transfer on both sides.
`define L2_LINE_W 256

// Cache geometry.
`define L2_SETS 16
`define L2_WAYS 4

// Address fields. Bits 4:0 select a byte in the line.
`define L2_IDX_LO 5
`define L2_TAG_LO 9

`endif

/* l2_cache_tb.sv */
`include "l2_cache_settings.svh"

module l2_cache_tb;

    localparam int ROWS = 32;
    localparam int LINES = 1 << (`L2_ADDR_W - `L2_IDX_LO);
    localparam logic RD = 1'b0;
    localparam logic WR = 1'b1;
    localparam logic ANY = 1'b0;
    localparam logic HIT = 1'b1;

    typedef struct packed {
        logic        write;
        logic [15:0] address;
        logic [15:0] seed;
        logic        must_hit;
    } stim_row;

    logic                 clk = 1'b0;
    logic                 reset;
    l2_cache_pkg::l2_word mem_address;
    logic                 mem_read;
    logic                 mem_write;
    l2_cache_pkg::l2_line mem_wdata;
    l2_cache_pkg::l2_line mem_rdata;
    logic                 mem_resp;
    l2_cache_pkg::l2_word pmem_address;
    logic                 pmem_read;
    logic                 pmem_write;
    l2_cache_pkg::l2_line pmem_wdata;
    l2_cache_pkg::l2_line pmem_rdata = '0;
    logic                 pmem_resp = 1'b0;
    logic                 expect_hit;

    l2_cache_pkg::l2_line phys_mem [LINES];
    logic [15:0]          lfsr;
    logic                 busy;
    int                   countdown;
    int                   checker_errors;

    // Sets 3 and 2 check plain hits, set 5 forces evictions, set 9 stacks dirty misses.
    stim_row table_rows [ROWS] = '{
        '{RD, 16'h0060, 16'h0000, ANY},
        '{RD, 16'h0060, 16'h0000, HIT},
        '{WR, 16'h0064, 16'h1111, HIT},
        '{RD, 16'h0060, 16'h0000, HIT},
        '{WR, 16'h0a40, 16'h2222, ANY},
        '{RD, 16'h0a4c, 16'h0000, HIT},
        '{WR, 16'h02a0, 16'h3101, ANY},
        '{WR, 16'h04a0, 16'h3202, ANY},
        '{WR, 16'h06a0, 16'h3303, ANY},
        '{WR, 16'h08a0, 16'h3404, ANY},
        '{WR, 16'h0aa0, 16'h3505, ANY},
        '{RD, 16'h02a0, 16'h0000, ANY},
        '{RD, 16'h0aa0, 16'h0000, HIT},
        '{RD, 16'h04a0, 16'h0000, HIT},
        '{RD, 16'h06a0, 16'h0000, ANY},
        '{RD, 16'h08a0, 16'h0000, ANY},
        '{WR, 16'h1520, 16'h4a0a, ANY},
        '{WR, 16'h1720, 16'h4b0b, ANY},
        '{WR, 16'h1920, 16'h4c0c, ANY},
        '{WR, 16'h1b20, 16'h4d0d, ANY},
        '{WR, 16'h1d20, 16'h4e0e, ANY},
        '{WR, 16'h1f20, 16'h4f0f, ANY},
        '{WR, 16'h1520, 16'h5a5a, ANY},
        '{WR, 16'h1720, 16'h5b5b, ANY},
        '{RD, 16'h1920, 16'h0000, ANY},
        '{RD, 16'h1b20, 16'h0000, ANY},
        '{RD, 16'h1d20, 16'h0000, ANY},
        '{RD, 16'h1f20, 16'h0000, ANY},
        '{RD, 16'h1520, 16'h0000, ANY},
        '{RD, 16'h02a0, 16'h0000, ANY},
        '{RD, 16'h0a40, 16'h0000, HIT},
        '{RD, 16'h0060, 16'h0000, HIT}
    };

    l2_cache l2_cache_i
    (
        .clk(clk), .reset(reset), .mem_address(mem_address), .mem_read(mem_read),
        .mem_write(mem_write), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .mem_resp(mem_resp), .pmem_address(pmem_address), .pmem_read(pmem_read),
        .pmem_write(pmem_write), .pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata),
        .pmem_resp(pmem_resp)
    );

    l2_cache_checker check_i
    (
        .clk(clk), .reset(reset), .expect_hit(expect_hit), .mem_address(mem_address),
        .mem_read(mem_read), .mem_write(mem_write), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_resp(mem_resp), .pmem_address(pmem_address),
        .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_wdata(pmem_wdata),
        .pmem_resp(pmem_resp), .error_count(checker_errors)
    );

    always #20 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic l2_cache_pkg::l2_line line_pattern(input int line_addr);
        l2_cache_pkg::l2_line line;
        for (int k = 0; k < `L2_LINE_W / 16; k++)
            line[k*16 +: 16] = 16'((line_addr << 5) | k) ^ 16'h3c5a;
        return line;
    endfunction

    function automatic l2_cache_pkg::l2_line spread_seed(input logic [15:0] seed);
        l2_cache_pkg::l2_line line;
        for (int k = 0; k < `L2_LINE_W / 16; k++)
            line[k*16 +: 16] = seed ^ (16'(k) * 16'h1001);
        return line;
    endfunction

    // Memory model. Each access waits 1 to 8 cycles as set by three LFSR bits.
    always @(posedge clk)
    begin
        logic [2:0] lat;
        if (reset)
        begin
            pmem_resp <= 1'b0;
            busy = 1'b0;
            lfsr = 16'd4694;
        end
        else
        begin
            pmem_resp <= 1'b0;
            if (busy)
            begin
                countdown = countdown - 1;
                if (countdown == 0)
                begin
                    busy = 1'b0;
                    pmem_resp <= 1'b1;
                    if (pmem_write)
                        phys_mem[pmem_address[`L2_ADDR_W-1:`L2_IDX_LO]] = pmem_wdata;
                    else
                        pmem_rdata <= phys_mem[pmem_address[`L2_ADDR_W-1:`L2_IDX_LO]];
                end
            end
            else if ((pmem_read || pmem_write) && !pmem_resp)
            begin
                for (int b = 0; b < 3; b++)
                begin
                    lfsr = lfsr_next(lfsr);
                    lat[b] = lfsr[0];
                end
                countdown = int'(lat) + 1;
                busy = 1'b1;
            end
        end
    end

    task automatic apply_row(input stim_row row);
        @(posedge clk);
        mem_address <= row.address;
        mem_read <= ~row.write;
        mem_write <= row.write;
        mem_wdata <= row.write ? spread_seed(row.seed) : '0;
        expect_hit <= row.must_hit;
        do
            @(posedge clk);
        while (!mem_resp);
        mem_read <= 1'b0;
        mem_write <= 1'b0;
    endtask

    initial
    begin
        reset <= 1'b1;
        mem_address <= '0;
        mem_read <= 1'b0;
        mem_write <= 1'b0;
        mem_wdata <= '0;
        expect_hit <= 1'b0;
        for (int a = 0; a < LINES; a++)
            phys_mem[a] = line_pattern(a);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // A few quiet cycles so the checker can see that nothing moves unasked.
        repeat (4) @(posedge clk);
        for (int r = 0; r < ROWS; r++)
            apply_row(table_rows[r]);
        repeat (12) @(posedge clk);
        $display("Errors: %0d in %0d requests", checker_errors, ROWS);
        if (checker_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial
    begin
        #(ROWS * 40 * 40);
        $display("Timeout: not every request was answered in time");
        $display("Something failed");
        $finish;
    end

endmodule : l2_cache_tb

/* pmem_arbiter.sv */
`include "l2_cache_settings.svh"

module pmem_arbiter
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wb_req,
    input  l2_cache_pkg::l2_word wb_address,
    input  l2_cache_pkg::l2_line wb_data,
    input  logic                 fill_req,
    input  l2_cache_pkg::l2_word fill_address,
    input  l2_cache_pkg::l2_line pmem_rdata,
    input  logic                 pmem_resp,
    output logic                 wb_done,
    output logic                 fill_done,
    output l2_cache_pkg::l2_line fill_data,
    output l2_cache_pkg::l2_word pmem_address,
    output logic                 pmem_read,
    output logic                 pmem_write,
    output l2_cache_pkg::l2_line pmem_wdata
);

    l2_cache_pkg::l2_bus_owner owner;

    // The buffer goes first, so a fill never reads a line still being written back.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            owner <= l2_cache_pkg::owner_none;
            pmem_read <= 1'b0;
            pmem_write <= 1'b0;
        end
        else if (owner == l2_cache_pkg::owner_none)
        begin
            if (wb_req)
            begin
                owner <= l2_cache_pkg::owner_buffer;
                pmem_write <= 1'b1;
            end
            else if (fill_req)
            begin
                owner <= l2_cache_pkg::owner_fill;
                pmem_read <= 1'b1;
            end
        end
        else if (pmem_resp)
        begin
            owner <= l2_cache_pkg::owner_none;
            pmem_read <= 1'b0;
            pmem_write <= 1'b0;
        end
    end

    assign pmem_address = (owner == l2_cache_pkg::owner_buffer) ? wb_address : fill_address;
    assign pmem_wdata = (owner == l2_cache_pkg::owner_buffer) ? wb_data : {`L2_LINE_W{1'b0}};

    assign wb_done = pmem_resp && (owner == l2_cache_pkg::owner_buffer);
    assign fill_done = pmem_resp && (owner == l2_cache_pkg::owner_fill);
    assign fill_data = pmem_rdata;

endmodule : pmem_arbiter
